// File: Bender.yml
package:
  name: a78_mem

export_include_dirs:
  - .

sources:
  - a78_pkg.sv
  - mem_req_if.sv
  - cart_loader_fsm.sv
  - sdram_port_mux.sv
  - paddle_timer.sv
  - a78_mem_top.sv
  - target: simulation
    files:
      - tb_a78_mem.sv

// File: a78_defines.svh
`ifndef A78_DEFINES_SVH
`define A78_DEFINES_SVH

// Bus widths
`define A78_DL_ADDR_W    27
`define A78_SD_ADDR_W    25
`define A78_BYTE_W       8

// 7800 cartridge image header
`define A78_HDR_LEN      128
`define A78_OFS_FLAGS_HI 53
`define A78_OFS_FLAGS_LO 54
`define A78_OFS_REGION   57   // 0 NTSC, 1 PAL
`define A78_OFS_SAVE     58   // 0 none, 1 high score cart, 2 savekey
`define A78_OFS_XM       63

// SDRAM region prefixes, placed in the top address bits
`define A78_BIOS_BASE    8'b1000_0001
`define A78_CRAM_BASE    5'b10000

// Clocks per paddle position step
`define A78_PAD_SCALE    4

`endif

// File: a78_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

module a78_mem_top import a78_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      i_rst_n,

	input  wire                      i_dl_active,
	input  wire                      i_dl_wr,
	input  wire [`A78_DL_ADDR_W-1:0] i_dl_addr,
	input  wire [`A78_BYTE_W-1:0]    i_dl_data,
	input  wire [7:0]                i_dl_index,

	input  wire                      i_cram_rd,
	input  wire                      i_cram_wr,
	input  wire [17:0]               i_cram_addr,
	input  wire [`A78_BYTE_W-1:0]    i_cram_wdata,
	input  wire                      i_bios_sel,
	input  wire [15:0]               i_bios_addr,
	input  wire                      i_cart_rd,
	input  wire [21:0]               i_cart_addr,

	input  wire [3:0][7:0]           i_paddle_pos,
	input  wire                      i_dump_n,

	output wire [`A78_SD_ADDR_W-1:0] o_sd_addr,
	output wire                      o_sd_rd,
	output wire                      o_sd_wr,
	output wire [`A78_BYTE_W-1:0]    o_sd_wdata,

	output wire [31:0]               o_cart_size,
	output wire [14:0]               o_bios_mask,
	output wire                      o_cart_is_7800,
	output wire                      o_tia_mode,
	output wire [15:0]               o_cart_flags,
	output wire [7:0]                o_cart_region,
	output wire [7:0]                o_cart_save,
	output wire [7:0]                o_cart_xm,
	output wire                      o_cart_loaded,
	output wire [3:0]                o_pad
);

	cart_info_t info;
	mem_req_if  dl_req ();

	// ==========================================================
	// Memory loading
	// ==========================================================
	cart_loader_fsm u_loader (
		.clk_sys       (clk_sys),
		.i_rst_n       (i_rst_n),
		.i_dl_active   (i_dl_active),
		.i_dl_wr       (i_dl_wr),
		.i_dl_addr     (i_dl_addr),
		.i_dl_data     (i_dl_data),
		.i_dl_index    (i_dl_index),
		.o_info        (info),
		.o_cart_size   (o_cart_size),
		.o_bios_mask   (o_bios_mask),
		.o_cart_loaded (o_cart_loaded),
		.o_req         (dl_req.loader)
	);

	sdram_port_mux u_mux (
		.clk_sys      (clk_sys),
		.i_rst_n      (i_rst_n),
		.i_dl_req     (dl_req.mux),
		.i_bios_mask  (o_bios_mask),   // Mask from the last BIOS load
		.i_cram_rd    (i_cram_rd),
		.i_cram_wr    (i_cram_wr),
		.i_cram_addr  (i_cram_addr),
		.i_cram_wdata (i_cram_wdata),
		.i_bios_sel   (i_bios_sel),
		.i_bios_addr  (i_bios_addr),
		.i_cart_rd    (i_cart_rd),
		.i_cart_addr  (i_cart_addr),
		.o_sd_addr    (o_sd_addr),
		.o_sd_rd      (o_sd_rd),
		.o_sd_wr      (o_sd_wr),
		.o_sd_wdata   (o_sd_wdata)
	);

	assign o_cart_is_7800 = info.is_7800;
	assign o_tia_mode     = info.tia_mode;
	assign o_cart_flags   = info.flags;
	assign o_cart_region  = info.region;
	assign o_cart_save    = info.save;
	assign o_cart_xm      = info.xm;

	// Paddles, one timer each and a shared dump line
	for (genvar gi = 0; gi < 4; gi++) begin : g_pad
		paddle_timer u_pad (
			.clk_sys  (clk_sys),
			.i_rst_n  (i_rst_n),
			.i_pos    (i_paddle_pos[gi]),
			.i_dump_n (i_dump_n),
			.o_pad    (o_pad[gi])
		);
	end

endmodule

`default_nettype wire

// File: a78_pkg.sv
`default_nettype none

`include "a78_defines.svh"

package a78_pkg;

	// Download classes, decoded from the download index
	typedef enum logic [1:0] {
		NONE,
		CART,
		BIOS,
		PALETTE
	} dl_kind_e;

	// Cartridge loader states
	typedef enum logic [1:0] {
		IDLE,
		HEADER,     // Bytes 0..127 of a 7800 image
		BODY,
		TIA_BODY    // 2600 image, no header
	} ld_state_e;

	// Fields parsed from the cartridge header
	typedef struct packed {
		logic        is_7800;   // Bytes 1..5 spell ATARI
		logic        tia_mode;
		logic [15:0] flags;
		logic [7:0]  region;
		logic [7:0]  save;
		logic [7:0]  xm;        // Bit 0 set for XM carts
	} cart_info_t;

	typedef logic [`A78_SD_ADDR_W-1:0] sd_addr_t;

endpackage

`default_nettype wire

// File: cart_loader_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

module cart_loader_fsm import a78_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      i_rst_n,
	input  wire                      i_dl_active,
	input  wire                      i_dl_wr,
	input  wire [`A78_DL_ADDR_W-1:0] i_dl_addr,
	input  wire [`A78_BYTE_W-1:0]    i_dl_data,
	input  wire [7:0]                i_dl_index,
	output cart_info_t               o_info,
	output logic [31:0]              o_cart_size,
	output logic [14:0]              o_bios_mask,
	output logic                     o_cart_loaded,
	mem_req_if.loader                o_req
);

	dl_kind_e    kind_c;
	ld_state_e   st_q;
	logic        cart_dl;
	logic        hdr_wr;
	logic [31:0] hdr_q;       // Header bytes 1..4
	sd_addr_t    wr_addr_c;

	// ==========================================================
	// Download classification
	// ==========================================================
	always_comb begin
		kind_c = NONE;
		if (i_dl_active) begin
			if (i_dl_index[5:0] == 6'd1)
				kind_c = CART;
			else if ((i_dl_index[5:0] == 6'd0 && i_dl_index[7:6] == 2'd0) ||
					i_dl_index[5:0] == 6'd2)
				kind_c = BIOS;
			else if (i_dl_index[5:0] == 6'd3)
				kind_c = PALETTE;
		end
	end

	assign cart_dl = (kind_c == CART);
	assign hdr_wr  = (st_q == HEADER) && i_dl_wr;

	// 7800 images are stored without their header
	assign wr_addr_c = (cart_dl && o_info.is_7800 && i_dl_addr >= `A78_HDR_LEN) ?
		sd_addr_t'(i_dl_addr - `A78_HDR_LEN) : sd_addr_t'(i_dl_addr);

	// ==========================================================
	// Loader FSM and header parsing
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (!i_rst_n) begin
			st_q          <= IDLE;
			o_info        <= '0;
			o_cart_size   <= 32'h0000_8000;   // 32K default
			o_bios_mask   <= '0;
			o_cart_loaded <= 1'b0;
		end else begin
			case (st_q)
				IDLE: begin
					if (cart_dl) begin
						o_info          <= '0;   // Fresh image
						o_info.tia_mode <= (i_dl_index[7:6] != 2'd0);
						o_cart_loaded   <= 1'b1;
						st_q            <= (i_dl_index[7:6] != 2'd0) ? TIA_BODY : HEADER;
					end
				end
				HEADER: begin
					if (!cart_dl)
						st_q <= IDLE;
					else if (i_dl_wr && i_dl_addr == `A78_HDR_LEN - 1)
						st_q <= BODY;
				end
				BODY, TIA_BODY: begin
					if (!cart_dl)
						st_q <= IDLE;
				end
				default: st_q <= IDLE;
			endcase

			if (hdr_wr) begin
				case (i_dl_addr)
					5:                 o_info.is_7800     <= ({hdr_q, i_dl_data} == "ATARI");
					`A78_OFS_FLAGS_HI: o_info.flags[15:8] <= i_dl_data;
					`A78_OFS_FLAGS_LO: o_info.flags[7:0]  <= i_dl_data;
					`A78_OFS_REGION:   o_info.region      <= i_dl_data;
					`A78_OFS_SAVE:     o_info.save        <= i_dl_data;
					`A78_OFS_XM:       o_info.xm          <= i_dl_data;
					default: ;
				endcase
			end

			if (cart_dl && i_dl_wr)
				o_cart_size <= 32'(i_dl_addr) + 32'd1 -
					(o_info.is_7800 ? 32'(`A78_HDR_LEN) : 32'd0);
			if (kind_c == BIOS && i_dl_wr)
				o_bios_mask <= i_dl_addr[14:0];   // BIOS image is a power of two
		end
	end

	// ==========================================================
	// Registered download request
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (!i_rst_n) begin
			o_req.wr   <= 1'b0;
			o_req.kind <= NONE;
		end else begin
			o_req.wr   <= i_dl_wr;
			o_req.kind <= kind_c;
		end
	end

	always_ff @(posedge clk_sys) begin
		o_req.addr  <= wr_addr_c;
		o_req.wdata <= i_dl_data;
		if (hdr_wr) begin
			case (i_dl_addr)
				1: hdr_q[31:24] <= i_dl_data;
				2: hdr_q[23:16] <= i_dl_data;
				3: hdr_q[15:8]  <= i_dl_data;
				4: hdr_q[7:0]   <= i_dl_data;
				default: ;
			endcase
		end
	end

	assign o_req.rd = 1'b0;   // Downloads only write

	a_no_hdr_in_tia: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		o_info.tia_mode |-> st_q != HEADER);

	a_wr_has_kind: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		o_req.wr |-> o_req.kind != NONE);

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
a78_pkg.sv
mem_req_if.sv
cart_loader_fsm.sv
sdram_port_mux.sv
paddle_timer.sv
a78_mem_top.sv
tb_a78_mem.sv

// File: mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

// One memory request from the download side towards the SDRAM mux
interface mem_req_if import a78_pkg::*; ();

	sd_addr_t               addr;
	logic                   rd;
	logic                   wr;      // One-cycle strobe
	logic [`A78_BYTE_W-1:0] wdata;
	dl_kind_e               kind;    // Class of the running download

	modport loader (
		output addr, rd, wr, wdata, kind
	);

	modport mux (
		input addr, rd, wr, wdata, kind
	);

endinterface

`default_nettype wire

// File: paddle_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

module paddle_timer (
	input  wire       clk_sys,
	input  wire       i_rst_n,
	input  wire [7:0] i_pos,      // Signed stick position
	input  wire       i_dump_n,   // Low holds the pot capacitor discharged
	output logic      o_pad
);

	logic [7:0]  pos_u;
	logic [10:0] target;
	logic [10:0] cnt_q;

	// Offset binary, -128 maps to 0
	assign pos_u  = {~i_pos[7], i_pos[6:0]};
	assign target = (11'(pos_u) + 11'd1) * 11'(`A78_PAD_SCALE);

	// ==========================================================
	// Charge timer
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (!i_rst_n) begin
			cnt_q <= '0;
			o_pad <= 1'b0;
		end else if (!i_dump_n) begin
			cnt_q <= '0;    // Dumped
			o_pad <= 1'b0;
		end else begin
			if (!o_pad)
				cnt_q <= cnt_q + 11'd1;   // Stops once charged
			if (cnt_q == target)
				o_pad <= 1'b1;
		end
	end

	// Output stays low for as long as the dump is held
	a_pad_low_in_dump: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		(!i_dump_n && $past(!i_dump_n)) |-> !o_pad);

endmodule

`default_nettype wire

// File: sdram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

module sdram_port_mux import a78_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      i_rst_n,
	mem_req_if.mux                   i_dl_req,
	input  wire [14:0]               i_bios_mask,
	input  wire                      i_cram_rd,
	input  wire                      i_cram_wr,
	input  wire [17:0]               i_cram_addr,
	input  wire [`A78_BYTE_W-1:0]    i_cram_wdata,
	input  wire                      i_bios_sel,
	input  wire [15:0]               i_bios_addr,
	input  wire                      i_cart_rd,
	input  wire [21:0]               i_cart_addr,
	output sd_addr_t                 o_sd_addr,
	output logic                     o_sd_rd,
	output logic                     o_sd_wr,
	output logic [`A78_BYTE_W-1:0]   o_sd_wdata
);

	logic                   dl_cart;
	logic                   dl_bios;
	logic                   dl_any;
	sd_addr_t               addr_c;
	logic                   rd_c;
	logic                   wr_c;
	logic [`A78_BYTE_W-1:0] wdata_c;

	assign dl_cart = (i_dl_req.kind == CART);
	assign dl_bios = (i_dl_req.kind == BIOS);
	assign dl_any  = dl_cart || dl_bios;   // Palette never touches SDRAM

	// Priority select, downloads first
	assign addr_c = dl_cart                  ? i_dl_req.addr :
	                dl_bios                  ? {`A78_BIOS_BASE, 17'(i_dl_req.addr[14:0])} :
	                (i_cram_rd || i_cram_wr) ? {`A78_CRAM_BASE, 20'(i_cram_addr)} :
	                i_bios_sel               ? {`A78_BIOS_BASE,
	                                            17'(i_bios_addr[14:0] & i_bios_mask)} :
	                                           sd_addr_t'(i_cart_addr);

	assign rd_c    = (i_cart_rd && !dl_any) || i_cram_rd || i_dl_req.rd;
	assign wr_c    = dl_any ? i_dl_req.wr : i_cram_wr;
	assign wdata_c = dl_any ? i_dl_req.wdata : i_cram_wdata;

	always_ff @(posedge clk_sys) begin
		if (!i_rst_n) begin
			o_sd_addr  <= '0;
			o_sd_rd    <= 1'b0;
			o_sd_wr    <= 1'b0;
			o_sd_wdata <= '0;
		end else begin
			o_sd_addr  <= addr_c;
			o_sd_rd    <= rd_c;
			o_sd_wr    <= wr_c;
			o_sd_wdata <= wdata_c;
		end
	end

	// Requesters never ask for a read and a write together
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		!(o_sd_rd && o_sd_wr));

endmodule

`default_nettype wire

// File: tb_a78_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "a78_defines.svh"

module tb_a78_mem;

	localparam int CART_LEN = 200;
	localparam int TIA_LEN  = 160;
	localparam int BIOS_LEN = 4096;
	// Two cycles per download byte, the longest paddle charge and the short tests
	localparam int TEST_CYCLES = 2 * (CART_LEN + TIA_LEN + BIOS_LEN) + 1100 + 60;
	localparam int CYCLE_LIMIT = TEST_CYCLES * 12 / 10;   // 20 percent margin
	localparam logic [24:0] BIOS_REGION = {`A78_BIOS_BASE, 17'd0};
	localparam logic [24:0] CRAM_REGION = {`A78_CRAM_BASE, 20'd0};

	logic                      clk_sys;
	logic                      i_rst_n;
	logic                      i_dl_active;
	logic                      i_dl_wr;
	logic [`A78_DL_ADDR_W-1:0] i_dl_addr;
	logic [`A78_BYTE_W-1:0]    i_dl_data;
	logic [7:0]                i_dl_index;
	logic                      i_cram_rd;
	logic                      i_cram_wr;
	logic [17:0]               i_cram_addr;
	logic [`A78_BYTE_W-1:0]    i_cram_wdata;
	logic                      i_bios_sel;
	logic [15:0]               i_bios_addr;
	logic                      i_cart_rd;
	logic [21:0]               i_cart_addr;
	logic [3:0][7:0]           i_paddle_pos;
	logic                      i_dump_n;
	wire  [`A78_SD_ADDR_W-1:0] o_sd_addr;
	wire                       o_sd_rd;
	wire                       o_sd_wr;
	wire  [`A78_BYTE_W-1:0]    o_sd_wdata;
	wire  [31:0]               o_cart_size;
	wire  [14:0]               o_bios_mask;
	wire                       o_cart_is_7800;
	wire                       o_tia_mode;
	wire  [15:0]               o_cart_flags;
	wire  [7:0]                o_cart_region;
	wire  [7:0]                o_cart_save;
	wire  [7:0]                o_cart_xm;
	wire                       o_cart_loaded;
	wire  [3:0]                o_pad;

	int         n_err;
	int         n_chk;
	int         cycle_cnt;
	int         n;
	int         rise [4];
	logic [7:0] pos_u;
	logic [7:0] img [0:CART_LEN-1];   // Image bytes of the running download

	a78_mem_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	// ==========================================================
	// Timing and priority checks
	// ==========================================================
	a_reset_quiet: assert property (@(posedge clk_sys)
		!i_rst_n |=> (!o_sd_rd && !o_sd_wr && o_pad == 4'd0))
		else begin
			n_err++;
			$display("SDRAM strobe or paddle active during reset");
		end

	a_dl_write_lands: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		(i_dl_active && i_dl_wr) |-> ##2 o_sd_wr)
		else begin
			n_err++;
			$display("Download write missing on SDRAM two cycles later");
		end

	a_no_cart_rd_in_dl: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		(i_dl_active && $past(i_dl_active) && i_cart_rd && !i_cram_rd) |=> !o_sd_rd)
		else begin
			n_err++;
			$display("Cartridge read reached SDRAM during a download");
		end

	a_cram_first: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
		(!i_dl_active && !$past(i_dl_active) && (i_cram_rd || i_cram_wr))
		|=> o_sd_addr[24:20] == `A78_CRAM_BASE)
		else begin
			n_err++;
			$display("Cartridge RAM access lost to a lower requester");
		end

	a_dump_holds_pad: assert property (@(posedge clk_sys) !i_dump_n |=> o_pad == 4'd0)
		else begin
			n_err++;
			$display("Paddle output rose while dump was held");
		end

	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		n_chk++;
		assert (act === exp) else begin
			n_err++;
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic start_download(input logic [7:0] index);
		i_dl_index  = index;
		i_dl_active = 1'b1;
		tick();
	endtask

	task automatic end_download();
		i_dl_active = 1'b0;
		tick();
		tick();
	endtask

	// One strobe, one idle cycle, then the write is on the SDRAM side
	task automatic send_byte(input string name, input int addr, input logic [7:0] data,
			input logic [24:0] exp_addr);
		i_dl_wr   = 1'b1;
		i_dl_addr = `A78_DL_ADDR_W'(addr);
		i_dl_data = data;
		tick();
		i_dl_wr = 1'b0;
		tick();
		check({name, " sd_wr"}, 32'd1, 32'(o_sd_wr));
		check({name, " sd_addr"}, 32'(exp_addr), 32'(o_sd_addr));
		check({name, " sd_wdata"}, 32'(data), 32'(o_sd_wdata));
	endtask

	initial begin
		n_err = 0;
		n_chk = 0;
		i_rst_n = 1'b0;
		i_dl_active = 1'b0;
		i_dl_wr = 1'b0;
		i_dl_addr = '0;
		i_dl_data = '0;
		i_dl_index = '0;
		i_cram_rd = 1'b0;
		i_cram_wr = 1'b1;   // Requests pending through reset
		i_cram_addr = '0;
		i_cram_wdata = '0;
		i_bios_sel = 1'b1;
		i_bios_addr = '0;
		i_cart_rd = 1'b1;
		i_cart_addr = '0;
		i_paddle_pos = '0;
		i_dump_n = 1'b0;
		void'($urandom(32'hfdb8));

		repeat (2) @(posedge clk_sys);
		#2;
		i_rst_n = 1'b1;
		i_cram_wr = 1'b0;
		i_bios_sel = 1'b0;
		i_cart_rd = 1'b0;
		check("reset sd_rd", 32'd0, 32'(o_sd_rd));
		check("reset sd_wr", 32'd0, 32'(o_sd_wr));
		check("reset loaded", 32'd0, 32'(o_cart_loaded));
		check("reset pad", 32'd0, 32'(o_pad));
		check("reset size", 32'd32768, o_cart_size);
		check("reset bios_mask", 32'd0, 32'(o_bios_mask));
		check("reset is_7800", 32'd0, 32'(o_cart_is_7800));

		// ==========================================================
		// 7800 image with its header skipped on the SDRAM side
		// ==========================================================
		for (int a = 0; a < CART_LEN; a++)
			img[a] = 8'($urandom);
		{img[1], img[2], img[3], img[4], img[5]} = "ATARI";
		start_download(8'h01);
		i_cart_rd   = 1'b1;   // Must stay off the SDRAM while loading
		i_cart_addr = 22'($urandom);
		for (int a = 0; a < CART_LEN; a++)
			send_byte("cart7800 write", a, img[a],
				(a >= `A78_HDR_LEN) ? 25'(a - `A78_HDR_LEN) : 25'(a));
		i_cart_rd = 1'b0;
		end_download();
		check("cart7800 is_7800", 32'd1, 32'(o_cart_is_7800));
		check("cart7800 tia_mode", 32'd0, 32'(o_tia_mode));
		check("cart7800 flags", 32'({img[`A78_OFS_FLAGS_HI], img[`A78_OFS_FLAGS_LO]}),
			32'(o_cart_flags));
		check("cart7800 region", 32'(img[`A78_OFS_REGION]), 32'(o_cart_region));
		check("cart7800 save", 32'(img[`A78_OFS_SAVE]), 32'(o_cart_save));
		check("cart7800 xm", 32'(img[`A78_OFS_XM]), 32'(o_cart_xm));
		check("cart7800 size", 32'(CART_LEN - `A78_HDR_LEN), o_cart_size);
		check("cart7800 loaded", 32'd1, 32'(o_cart_loaded));

		// 2600 image with a fake signature that must be ignored
		for (int a = 0; a < TIA_LEN; a++)
			img[a] = 8'($urandom);
		{img[1], img[2], img[3], img[4], img[5]} = "ATARI";
		start_download(8'h41);
		for (int a = 0; a < TIA_LEN; a++)
			send_byte("tia write", a, img[a], 25'(a));
		end_download();
		check("tia tia_mode", 32'd1, 32'(o_tia_mode));
		check("tia is_7800", 32'd0, 32'(o_cart_is_7800));
		check("tia header", 32'd0,
			32'({o_cart_flags, o_cart_region, o_cart_save}) | 32'(o_cart_xm));
		check("tia size", 32'(TIA_LEN), o_cart_size);

		// ==========================================================
		// BIOS load and fetch
		// ==========================================================
		start_download(8'h00);
		for (int a = 0; a < BIOS_LEN; a++)
			send_byte("bios write", a, 8'($urandom), BIOS_REGION + 25'(a));
		end_download();
		check("bios mask", 32'(BIOS_LEN - 1), 32'(o_bios_mask));
		i_bios_sel  = 1'b1;
		i_bios_addr = 16'h5123;
		i_cart_rd   = 1'b1;
		i_cart_addr = 22'($urandom);
		tick();
		check("bios read addr", 32'(BIOS_REGION + 25'h0123), 32'(o_sd_addr));
		check("bios read rd", 32'd1, 32'(o_sd_rd));

		// Cartridge RAM over BIOS and cartridge reads
		i_cram_rd   = 1'b1;
		i_cram_addr = 18'($urandom);
		tick();
		check("cram read addr", 32'(CRAM_REGION + 25'(i_cram_addr)), 32'(o_sd_addr));
		check("cram read rd", 32'd1, 32'(o_sd_rd));
		i_cram_rd    = 1'b0;
		i_cart_rd    = 1'b0;
		i_cram_wr    = 1'b1;
		i_cram_wdata = 8'($urandom);
		tick();
		check("cram write addr", 32'(CRAM_REGION + 25'(i_cram_addr)), 32'(o_sd_addr));
		check("cram write wr", 32'd1, 32'(o_sd_wr));
		check("cram write data", 32'(i_cram_wdata), 32'(o_sd_wdata));
		i_cram_wr  = 1'b0;
		i_bios_sel = 1'b0;
		i_cart_rd  = 1'b1;
		tick();
		check("cart read addr", 32'(i_cart_addr), 32'(o_sd_addr));
		check("cart read rd", 32'd1, 32'(o_sd_rd));
		i_cart_rd = 1'b0;

		// ==========================================================
		// Paddles
		// ==========================================================
		for (int p = 0; p < 4; p++) begin
			i_paddle_pos[p] = 8'($urandom);
			rise[p] = -1;
		end
		repeat (4) tick();
		check("paddle held", 32'd0, 32'(o_pad));
		i_dump_n = 1'b1;
		n = 0;
		while ((rise[0] < 0 || rise[1] < 0 || rise[2] < 0 || rise[3] < 0) && n < 1100) begin
			tick();
			n++;
			for (int p = 0; p < 4; p++)
				if (o_pad[p] && rise[p] < 0)
					rise[p] = n - 1;   // Cycles after the first clock that saw release
		end
		for (int p = 0; p < 4; p++) begin
			pos_u = 8'($signed(i_paddle_pos[p]) + 128);   // Signed stick moved into 0..255
			if (rise[p] < 0) begin
				n_err++;
				$display("Paddle %0d output never rose after dump release", p);
			end else
				check($sformatf("paddle %0d rise", p),
					32'((int'(pos_u) + 1) * `A78_PAD_SCALE), 32'(rise[p]));
		end
		i_dump_n = 1'b0;
		repeat (2) tick();
		check("paddle dumped", 32'd0, 32'(o_pad));

		$display("Checks: %0d, errors: %0d", n_chk, n_err);
		if (n_err == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
